/* hdl/tomasuloPkg.sv */
package tomasuloPkg;

    localparam int REG_COUNT = 32;
    localparam int TAG_COUNT = 16;

    typedef logic [31:0] wordT;
    typedef logic [$clog2(REG_COUNT)-1:0] regAddrT;
    typedef logic [$clog2(TAG_COUNT)-1:0] tagT;

    // zero tag means value present with no producer
    localparam tagT TAG_NONE = '0;

    // adder stations count up from tag 1, multiplier stations follow them
    function automatic tagT bankFirstTag(int stationsBefore);
        return tagT'(stationsBefore + 1);
    endfunction

endpackage

/* hdl/stationBus.sv */
interface stationBus;

    // bank status
    logic full;
    tomasuloPkg::tagT freeTag;

    // operands and qualifier from the rename unit
    logic issue;
    tomasuloPkg::tagT qj;
    tomasuloPkg::tagT qk;
    tomasuloPkg::wordT vj;
    tomasuloPkg::wordT vk;

    modport bank (
        output full,
        output freeTag,
        input  issue,
        input  qj,
        input  qk,
        input  vj,
        input  vk
    );

    modport rename (
        input  full,
        input  freeTag,
        output issue,
        output qj,
        output qk,
        output vj,
        output vk
    );

endinterface

/* hdl/stationBank.sv */
module stationBank #(
    parameter int entries = 3,
    parameter tomasuloPkg::tagT firstTag = 1
) (
    input  logic               clk,
    input  logic               reset,
    stationBus.bank            bus,
    input  logic               cdbValid,
    input  tomasuloPkg::tagT   cdbTag,
    input  tomasuloPkg::wordT  cdbData,
    output logic [entries-1:0] start,
    output tomasuloPkg::wordT  srcA [entries],
    output tomasuloPkg::wordT  srcB [entries],
    output tomasuloPkg::tagT   unitTag [entries]
);

    logic [entries-1:0] busy;
    logic [entries-1:0] fired;
    tomasuloPkg::wordT vj [entries];
    tomasuloPkg::wordT vk [entries];
    tomasuloPkg::tagT qj [entries];
    tomasuloPkg::tagT qk [entries];
    tomasuloPkg::tagT ownTag [entries];

    logic [entries-1:0] allocHot;
    logic [entries-1:0] take;
    logic [entries-1:0] capJ;
    logic [entries-1:0] capK;
    logic [entries-1:0] done;
    logic [entries-1:0] ready;

    assign bus.full = &busy;

    // lowest idle station gets the next issue
    always_comb begin
        allocHot = '0;
        bus.freeTag = firstTag;
        for (int i = entries - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                allocHot = '0;
                allocHot[i] = 1'b1;
                bus.freeTag = firstTag + tomasuloPkg::tagT'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < entries; i++) begin
            ownTag[i] = firstTag + tomasuloPkg::tagT'(i);
            take[i] = bus.issue && allocHot[i];

            // operand wake-up from the CDB
            capJ[i] = cdbValid && busy[i] && qj[i] != tomasuloPkg::TAG_NONE
                && qj[i] == cdbTag;
            capK[i] = cdbValid && busy[i] && qk[i] != tomasuloPkg::TAG_NONE
                && qk[i] == cdbTag;

            // own result on the CDB frees the station
            done[i] = cdbValid && busy[i] && ownTag[i] == cdbTag;

            ready[i] = busy[i] && !fired[i]
                && qj[i] == tomasuloPkg::TAG_NONE
                && qk[i] == tomasuloPkg::TAG_NONE;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= '0;
            fired <= '0;
            start <= '0;
        end else begin
            for (int i = 0; i < entries; i++) begin
                if (take[i]) begin
                    busy[i] <= 1'b1;
                    fired[i] <= 1'b0;
                end else if (done[i]) begin
                    busy[i] <= 1'b0;
                    fired[i] <= 1'b0;
                end else if (ready[i]) begin
                    fired[i] <= 1'b1;
                end
            end
            // one-cycle start per ready station
            start <= ready;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < entries; i++) begin
            if (take[i]) begin
                vj[i] <= bus.vj;
                vk[i] <= bus.vk;
                qj[i] <= bus.qj;
                qk[i] <= bus.qk;
            end else begin
                if (capJ[i]) begin
                    vj[i] <= cdbData;
                    qj[i] <= tomasuloPkg::TAG_NONE;
                end
                if (capK[i]) begin
                    vk[i] <= cdbData;
                    qk[i] <= tomasuloPkg::TAG_NONE;
                end
            end

            if (ready[i]) begin
                srcA[i] <= vj[i];
                srcB[i] <= vk[i];
                unitTag[i] <= ownTag[i];
            end
        end
    end

endmodule

/* hdl/renameUnit.sv */
module renameUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  tomasuloPkg::regAddrT rs,
    input  tomasuloPkg::regAddrT rt,
    input  tomasuloPkg::regAddrT rd,
    input  logic                 addEn,
    input  logic                 mulEn,
    input  logic                 immInstr,
    input  tomasuloPkg::wordT    extImm,
    input  tomasuloPkg::wordT    readData1,
    input  tomasuloPkg::wordT    readData2,
    output tomasuloPkg::regAddrT readAddr1,
    output tomasuloPkg::regAddrT readAddr2,
    output logic                 stall,
    stationBus.rename            addBus,
    stationBus.rename            mulBus,
    input  logic                 cdbValid,
    input  tomasuloPkg::tagT     cdbTag,
    input  tomasuloPkg::wordT    cdbData,
    output logic                 regWriteValid,
    output tomasuloPkg::regAddrT regWriteAddr,
    output tomasuloPkg::wordT    regWriteData
);

    tomasuloPkg::tagT regStat [tomasuloPkg::REG_COUNT];

    logic useAdd;
    logic useMul;
    logic accept;
    logic useImm;
    tomasuloPkg::tagT newTag;

    tomasuloPkg::tagT pendJ;
    tomasuloPkg::tagT pendK;
    logic hitJ;
    logic hitK;

    logic [tomasuloPkg::REG_COUNT-1:0] clearHit;
    logic wbHit;
    tomasuloPkg::regAddrT wbAddr;

    assign readAddr1 = rs;
    assign readAddr2 = rt;

    // add takes priority when both enables are up
    assign useAdd = addEn;
    assign useMul = !addEn && mulEn;
    assign stall = (useAdd && addBus.full) || (useMul && mulBus.full);
    assign accept = (useAdd || useMul) && !stall;
    assign useImm = useAdd && immInstr;
    assign newTag = useAdd ? addBus.freeTag : mulBus.freeTag;

    // producer already on the CDB this cycle supplies the value directly
    assign pendJ = regStat[rs];
    assign pendK = regStat[rt];
    assign hitJ = cdbValid && pendJ != tomasuloPkg::TAG_NONE && pendJ == cdbTag;
    assign hitK = cdbValid && pendK != tomasuloPkg::TAG_NONE && pendK == cdbTag;

    assign addBus.issue = useAdd && !addBus.full;
    assign mulBus.issue = useMul && !mulBus.full;

    assign addBus.qj = hitJ ? tomasuloPkg::TAG_NONE : pendJ;
    assign addBus.vj = hitJ ? cdbData : readData1;
    assign addBus.qk = (useImm || hitK) ? tomasuloPkg::TAG_NONE : pendK;
    assign addBus.vk = useImm ? extImm : (hitK ? cdbData : readData2);

    // no immediate form on the multiply path
    assign mulBus.qj = hitJ ? tomasuloPkg::TAG_NONE : pendJ;
    assign mulBus.vj = hitJ ? cdbData : readData1;
    assign mulBus.qk = hitK ? tomasuloPkg::TAG_NONE : pendK;
    assign mulBus.vk = hitK ? cdbData : readData2;

    always_comb begin
        wbHit = 1'b0;
        wbAddr = '0;
        for (int r = 0; r < tomasuloPkg::REG_COUNT; r++) begin
            clearHit[r] = cdbValid && regStat[r] != tomasuloPkg::TAG_NONE
                && regStat[r] == cdbTag;
            if (clearHit[r]) begin
                wbHit = 1'b1;
                wbAddr = tomasuloPkg::regAddrT'(r);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < tomasuloPkg::REG_COUNT; r++) begin
                regStat[r] <= tomasuloPkg::TAG_NONE;
            end
            regWriteValid <= 1'b0;
        end else begin
            for (int r = 0; r < tomasuloPkg::REG_COUNT; r++) begin
                // a new rename overrides the clear on the same edge
                if (accept && rd == tomasuloPkg::regAddrT'(r)) begin
                    regStat[r] <= newTag;
                end else if (clearHit[r]) begin
                    regStat[r] <= tomasuloPkg::TAG_NONE;
                end
            end
            regWriteValid <= wbHit;
        end
    end

    always_ff @(posedge clk) begin
        if (wbHit) begin
            regWriteAddr <= wbAddr;
            regWriteData <= cdbData;
        end
    end

endmodule

/* hdl/reservationStation.sv */
module reservationStation #(
    parameter int addStations = 3,
    parameter int mulStations = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  tomasuloPkg::regAddrT   rs,
    input  tomasuloPkg::regAddrT   rt,
    input  tomasuloPkg::regAddrT   rd,
    input  logic                   addEn,
    input  logic                   mulEn,
    input  logic                   immInstr,
    input  tomasuloPkg::wordT      extImm,
    input  tomasuloPkg::wordT      readData1,
    input  tomasuloPkg::wordT      readData2,
    input  logic                   cdbValid,
    input  tomasuloPkg::tagT       cdbTag,
    input  tomasuloPkg::wordT      cdbData,
    output tomasuloPkg::regAddrT   readAddr1,
    output tomasuloPkg::regAddrT   readAddr2,
    output logic                   stall,
    output logic [addStations-1:0] addStart,
    output tomasuloPkg::wordT      addSrcA [addStations],
    output tomasuloPkg::wordT      addSrcB [addStations],
    output tomasuloPkg::tagT       addTag [addStations],
    output logic [mulStations-1:0] mulStart,
    output tomasuloPkg::wordT      mulSrcA [mulStations],
    output tomasuloPkg::wordT      mulSrcB [mulStations],
    output tomasuloPkg::tagT       mulTag [mulStations],
    output logic                   regWriteValid,
    output tomasuloPkg::regAddrT   regWriteAddr,
    output tomasuloPkg::wordT      regWriteData
);

    // multiplier tags start right after the adder tags
    localparam tomasuloPkg::tagT addFirstTag = tomasuloPkg::bankFirstTag(0);
    localparam tomasuloPkg::tagT mulFirstTag = tomasuloPkg::bankFirstTag(addStations);

    stationBus addBus ();
    stationBus mulBus ();

    renameUnit rename (
        .clk(clk), .reset(reset),
        .rs(rs), .rt(rt), .rd(rd),
        .addEn(addEn), .mulEn(mulEn), .immInstr(immInstr), .extImm(extImm),
        .readData1(readData1), .readData2(readData2),
        .readAddr1(readAddr1), .readAddr2(readAddr2), .stall(stall),
        .addBus(addBus), .mulBus(mulBus),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .regWriteValid(regWriteValid), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData)
    );

    stationBank #(.entries(addStations), .firstTag(addFirstTag)) addBank (
        .clk(clk), .reset(reset), .bus(addBus),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .start(addStart), .srcA(addSrcA), .srcB(addSrcB), .unitTag(addTag)
    );

    stationBank #(.entries(mulStations), .firstTag(mulFirstTag)) mulBank (
        .clk(clk), .reset(reset), .bus(mulBus),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .start(mulStart), .srcA(mulSrcA), .srcB(mulSrcB), .unitTag(mulTag)
    );

endmodule

/* sim/reservationStationTb.sv */
module reservationStationTb;

    localparam int addStations = 3;
    localparam int mulStations = 2;
    localparam int maxRecords = 256;

    localparam int recIssue = 0;
    localparam int recCast = 1;
    localparam int recIdle = 2;
    localparam int recStart = 3;
    localparam int recWrite = 4;
    localparam int recNoWrite = 5;
    localparam int recStall = 6;

    logic clk = 1'b0;
    logic reset = 1'b1;
    tomasuloPkg::regAddrT rs = '0;
    tomasuloPkg::regAddrT rt = '0;
    tomasuloPkg::regAddrT rd = '0;
    logic addEn = 1'b0;
    logic mulEn = 1'b0;
    logic immInstr = 1'b0;
    tomasuloPkg::wordT extImm = '0;
    tomasuloPkg::wordT readData1 = '0;
    tomasuloPkg::wordT readData2 = '0;
    logic cdbValid = 1'b0;
    tomasuloPkg::tagT cdbTag = '0;
    tomasuloPkg::wordT cdbData = '0;

    tomasuloPkg::regAddrT readAddr1;
    tomasuloPkg::regAddrT readAddr2;
    logic stall;
    logic [addStations-1:0] addStart;
    tomasuloPkg::wordT addSrcA [addStations];
    tomasuloPkg::wordT addSrcB [addStations];
    tomasuloPkg::tagT addTag [addStations];
    logic [mulStations-1:0] mulStart;
    tomasuloPkg::wordT mulSrcA [mulStations];
    tomasuloPkg::wordT mulSrcB [mulStations];
    tomasuloPkg::tagT mulTag [mulStations];
    logic regWriteValid;
    tomasuloPkg::regAddrT regWriteAddr;
    tomasuloPkg::wordT regWriteData;

    int recCode [maxRecords];
    logic [31:0] fld [maxRecords][8];
    int recCount = 0;
    int cycleLimit = 0;
    int cycles = 0;
    logic pending = 1'b0;

    reservationStation #(.addStations(addStations), .mulStations(mulStations)) uut (.*);

    always #2 clk = ~clk;

    // run length bound from the number of records
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            abortRun($sformatf("timeout: the test records did not finish in %0d cycles",
                cycleLimit));
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string msg);
        abortRun($sformatf("Fail %0t: %s", $time, msg));
    endtask

    task automatic checkStart(input logic started, input tomasuloPkg::tagT gotTag,
                              input tomasuloPkg::tagT expTag,
                              input tomasuloPkg::wordT gotA, input tomasuloPkg::wordT expA,
                              input tomasuloPkg::wordT gotB, input tomasuloPkg::wordT expB);
        if (started !== 1'b1 || gotTag !== expTag || gotA !== expA || gotB !== expB) begin
            reportMismatch($sformatf("start %b tag %0d a %h b %h, expected tag %0d a %h b %h",
                started, gotTag, gotA, gotB, expTag, expA, expB));
        end
    endtask

    task automatic checkWrite(input logic valid, input tomasuloPkg::regAddrT gotAddr,
                              input tomasuloPkg::regAddrT expAddr,
                              input tomasuloPkg::wordT gotData, input tomasuloPkg::wordT expData);
        if (valid !== 1'b1 || gotAddr !== expAddr || gotData !== expData) begin
            reportMismatch($sformatf("write %b r%0d %h, expected r%0d %h",
                valid, gotAddr, gotData, expAddr, expData));
        end
    endtask

    task automatic checkNoWrite(input logic valid);
        if (valid !== 1'b0) begin
            reportMismatch($sformatf("unexpected write to r%0d", regWriteAddr));
        end
    endtask

    task automatic checkStall(input logic got, input logic expected);
        if (got !== expected) begin
            reportMismatch($sformatf("stall %b, expected %b", got, expected));
        end
    endtask

    task automatic checkReadAddr(input tomasuloPkg::regAddrT got,
                                 input tomasuloPkg::regAddrT expected);
        if (got !== expected) begin
            reportMismatch($sformatf("read address %0d, expected %0d", got, expected));
        end
    endtask

    // one clock edge; a held issue leaves once stall was low before the edge
    task automatic tick();
        logic stallSeen;
        @(negedge clk);
        stallSeen = stall;
        @(posedge clk);
        #1;
        cdbValid = 1'b0;
        if (pending && !stallSeen) begin
            pending = 1'b0;
            addEn = 1'b0;
            mulEn = 1'b0;
        end
    endtask

    task automatic loadTests();
        int fd;
        int n;
        logic [8*16-1:0] word;
        logic [8*16-1:0] op;
        logic [8*256-1:0] line;
        logic [31:0] v [7];
        fd = $fopen("sim/stationTests.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open the test file sim/stationTests.txt");
        end
        while (!$feof(fd) && recCount < maxRecords) begin
            n = $fscanf(fd, "%s", word);
            if (n != 1) break;
            for (int k = 0; k < 8; k++) begin
                fld[recCount][k] = '0;
            end
            if (word == "#") begin
                n = $fgets(line, fd);
            end else if (word == "issue") begin
                n = $fscanf(fd, "%s %h %h %h %h %h %h %h", op, v[0], v[1], v[2], v[3], v[4],
                    v[5], v[6]);
                recCode[recCount] = recIssue;
                fld[recCount][0] = (op == "mul") ? 32'd1 : 32'd0;
                for (int k = 0; k < 7; k++) begin
                    fld[recCount][k+1] = v[k];
                end
                recCount++;
            end else if (word == "broadcast") begin
                n = $fscanf(fd, "%h %h", fld[recCount][0], fld[recCount][1]);
                recCode[recCount] = recCast;
                recCount++;
            end else if (word == "idle") begin
                n = $fscanf(fd, "%h", fld[recCount][0]);
                recCode[recCount] = recIdle;
                recCount++;
            end else if (word == "expectStart") begin
                n = $fscanf(fd, "%s %h %h %h %h", op, v[0], v[1], v[2], v[3]);
                recCode[recCount] = recStart;
                fld[recCount][0] = (op == "mul") ? 32'd1 : 32'd0;
                for (int k = 0; k < 4; k++) begin
                    fld[recCount][k+1] = v[k];
                end
                recCount++;
            end else if (word == "expectWrite") begin
                n = $fscanf(fd, "%h %h", fld[recCount][0], fld[recCount][1]);
                recCode[recCount] = recWrite;
                recCount++;
            end else if (word == "expectNoWrite") begin
                recCode[recCount] = recNoWrite;
                recCount++;
            end else if (word == "expectStall") begin
                n = $fscanf(fd, "%h", fld[recCount][0]);
                recCode[recCount] = recStall;
                recCount++;
            end else begin
                abortRun($sformatf("the test file holds an unknown keyword: %0s", word));
            end
        end
        $fclose(fd);
        if (recCount == 0) begin
            abortRun("the test file sim/stationTests.txt holds no records");
        end
    endtask

    initial begin
        int idx;
        loadTests();
        cycleLimit = 20 * recCount + 50;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < recCount; i++) begin
            idx = int'(fld[i][1]);
            case (recCode[i])
                recIssue: begin
                    addEn = (fld[i][0] == 0);
                    mulEn = (fld[i][0] == 1);
                    rs = fld[i][1][4:0];
                    rt = fld[i][2][4:0];
                    rd = fld[i][3][4:0];
                    immInstr = fld[i][4][0];
                    extImm = fld[i][5];
                    readData1 = fld[i][6];
                    readData2 = fld[i][7];
                    pending = 1'b1;
                    tick();
                    // register file is read at rs and rt
                    checkReadAddr(readAddr1, fld[i][1][4:0]);
                    checkReadAddr(readAddr2, fld[i][2][4:0]);
                end
                recCast: begin
                    // takes effect at the next edge, together with any issue
                    cdbValid = 1'b1;
                    cdbTag = fld[i][0][3:0];
                    cdbData = fld[i][1];
                end
                recIdle: begin
                    repeat (int'(fld[i][0])) tick();
                end
                recStart: begin
                    if (fld[i][0] == 1) begin
                        checkStart(mulStart[idx], mulTag[idx], fld[i][4][3:0],
                            mulSrcA[idx], fld[i][2], mulSrcB[idx], fld[i][3]);
                    end else begin
                        checkStart(addStart[idx], addTag[idx], fld[i][4][3:0],
                            addSrcA[idx], fld[i][2], addSrcB[idx], fld[i][3]);
                    end
                end
                recWrite: begin
                    checkWrite(regWriteValid, regWriteAddr, fld[i][0][4:0],
                        regWriteData, fld[i][1]);
                end
                recNoWrite: begin
                    checkNoWrite(regWriteValid);
                end
                default: begin
                    checkStall(stall, fld[i][0][0]);
                end
            endcase
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* sim/stationTests.txt */
# all numbers hex; issue op rs rt rd imm extImm readData1 readData2 | broadcast tag data
# idle n | expectStart unit idx srcA srcB tag | expectWrite reg data | expectNoWrite | expectStall v
issue add 1 2 3 0 0 10 20
idle 1
expectStart add 0 10 20 1
issue add 4 5 6 1 fffffff0 5 99
issue mul 7 8 9 0 0 3 4
expectStart add 1 5 fffffff0 2
idle 1
expectStart mul 0 3 4 4
issue add 9 1 a 0 0 0 7
idle 2
broadcast 4 c
idle 1
expectWrite 9 c
idle 1
expectStart add 2 c 7 3
issue add b c d 0 0 100 200
expectStall 1
broadcast 1 30
idle 1
expectWrite 3 30
expectStall 0
idle 2
expectStart add 0 100 200 1
issue mul 0 0 e 0 0 2 3
issue mul 0 0 e 0 0 4 5
broadcast 4 55
idle 1
expectNoWrite
broadcast 5 66
idle 1
expectWrite e 66
issue mul 0 0 f 0 0 6 7
broadcast 4 77
issue mul f 0 10 0 0 dead 2
expectWrite f 77
idle 1
expectStart mul 1 77 2 5

/* all.f */
hdl/tomasuloPkg.sv
hdl/stationBus.sv
hdl/stationBank.sv
hdl/renameUnit.sv
hdl/reservationStation.sv
sim/reservationStationTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = reservationStationTb
FILELIST = all.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
